// ==== source/obi_integrity_pkg.sv ====
// OBI data port integrity monitor definitions
// Checksum layout, register map, record depth and fault group codes
`default_nettype none

package obi_integrity_pkg;

  // OBI bus widths
  localparam int OBI_ADDR_W = 32;
  localparam int OBI_DATA_W = 32;
  localparam int OBI_BE_W   = OBI_DATA_W / 8;

  // Checksum widths, rchk bit 4 covers err and exokay
  localparam int ACHK_W         = 13;
  localparam int RCHK_W         = 5;
  localparam int RCHK_STORE_BIT = 4;

  // Wishbone register map, word addresses
  localparam int WB_ADDR_W = 3;
  localparam int WB_DATA_W = 32;
  localparam logic [WB_ADDR_W-1:0] REG_CTRL     = 3'd0;
  localparam logic [WB_ADDR_W-1:0] REG_STATUS   = 3'd1;
  localparam logic [WB_ADDR_W-1:0] REG_PAR_CNT  = 3'd2;
  localparam logic [WB_ADDR_W-1:0] REG_ACHK_CNT = 3'd3;
  localparam logic [WB_ADDR_W-1:0] REG_RCHK_CNT = 3'd4;
  localparam int CTRL_EN_BIT  = 0;
  localparam int CTRL_CLR_BIT = 1;
  localparam int CNT_W        = 16;

  // Outstanding request record
  localparam int OBI_MAX_OUTSTANDING = 2;
  localparam int REC_PTR_W = (OBI_MAX_OUTSTANDING > 1) ? $clog2(OBI_MAX_OUTSTANDING) : 1;
  localparam int REC_CNT_W = $clog2(OBI_MAX_OUTSTANDING + 1);

  // Fault group codes, also reported in STATUS[3:1]
  localparam int GRP_W = 3;
  localparam logic [GRP_W-1:0] GRP_NONE       = 3'd0;
  localparam logic [GRP_W-1:0] GRP_PARITY     = 3'd1;
  localparam logic [GRP_W-1:0] GRP_ACHK_WDATA = 3'd2;
  localparam logic [GRP_W-1:0] GRP_ACHK_CTRL  = 3'd3;
  localparam logic [GRP_W-1:0] GRP_ACHK_ADDR  = 3'd4;
  localparam logic [GRP_W-1:0] GRP_RCHK       = 3'd5;

  // Request checksum, seen flat or as parity groups (MSB first)
  typedef union packed {
    logic [ACHK_W-1:0] flat;
    struct packed {
      logic [3:0] wdata_par;
      logic       dbg_ipar;
      logic       atop_par;
      logic       mid_par;
      logic       bewe_ipar;
      logic       protmem_ipar;
      logic [3:0] addr_par;
    } fld;
  } achk_u;

endpackage

`default_nettype wire

// ==== source/obi_handshake_decode.sv ====
// OBI handshake parity check and outstanding request record
// Tracks we, integrity enable and grant parity faults per accepted request
`default_nettype none

module obi_handshake_decode
  import obi_integrity_pkg::*;
(
  input  wire  clk_i,
  input  wire  rst_n_i,
  input  wire  req_i,
  input  wire  reqpar_i,
  input  wire  gnt_i,
  input  wire  gntpar_i,
  input  wire  rvalid_i,
  input  wire  rvalidpar_i,
  input  wire  we_i,
  input  wire  integrity_en_i,
  output logic par_fault_o,
  output logic resp_we_o,
  output logic resp_had_integrity_o,
  output logic gnt_fault_resp_o
);

  logic accept;
  logic req_fault;
  logic gnt_fault;
  logic rvalid_fault;
  logic gnt_fault_pend_q;
  logic gnt_fault_push;

  // Record payload and circular pointers
  logic                 rec_we    [OBI_MAX_OUTSTANDING];
  logic                 rec_integ [OBI_MAX_OUTSTANDING];
  logic                 rec_gntf  [OBI_MAX_OUTSTANDING];
  logic [REC_PTR_W-1:0] wr_ptr_q;
  logic [REC_PTR_W-1:0] rd_ptr_q;
  logic [REC_CNT_W-1:0] count_q;

  // Parity line must be the complement of its signal
  assign req_fault    = (reqpar_i == req_i);
  assign gnt_fault    = (gntpar_i == gnt_i);
  assign rvalid_fault = (rvalidpar_i == rvalid_i);
  assign par_fault_o  = req_fault | gnt_fault | rvalid_fault;

  assign accept = req_i & gnt_i;

  // A grant fault while the request waits belongs to that request
  assign gnt_fault_push = gnt_fault | gnt_fault_pend_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      gnt_fault_pend_q <= 1'b0;
    end else if (accept) begin
      gnt_fault_pend_q <= 1'b0;
    end else if (req_i && gnt_fault) begin
      gnt_fault_pend_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      rec_we[wr_ptr_q]    <= we_i;
      rec_integ[wr_ptr_q] <= integrity_en_i;
      rec_gntf[wr_ptr_q]  <= gnt_fault_push;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (accept) begin
        wr_ptr_q <= (wr_ptr_q == REC_PTR_W'(OBI_MAX_OUTSTANDING - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (rvalid_i) begin
        rd_ptr_q <= (rd_ptr_q == REC_PTR_W'(OBI_MAX_OUTSTANDING - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({accept, rvalid_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Oldest open request describes the current response
  assign resp_we_o            = rec_we[rd_ptr_q];
  assign resp_had_integrity_o = rec_integ[rd_ptr_q];
  assign gnt_fault_resp_o     = rec_gntf[rd_ptr_q];

  // Responses need an earlier accept still open
  a_rvalid_has_request: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    rvalid_i |-> (count_q != '0)
  ) else $error("rvalid with no outstanding OBI request");

  a_accept_not_full: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    accept |-> (count_q != REC_CNT_W'(OBI_MAX_OUTSTANDING))
  ) else $error("OBI accept with the outstanding record full");

endmodule

`default_nettype wire

// ==== source/obi_checksum_execute.sv ====
// OBI checksum recompute and compare
// Checks achk on each accepted request and rchk on each response
`default_nettype none

module obi_checksum_execute
  import obi_integrity_pkg::*;
(
  input  wire                    clk_i,
  input  wire                    rst_n_i,
  input  wire                    req_i,
  input  wire                    gnt_i,
  input  wire [OBI_ADDR_W-1:0]   addr_i,
  input  wire [OBI_DATA_W-1:0]   wdata_i,
  input  wire [OBI_BE_W-1:0]     be_i,
  input  wire                    we_i,
  input  wire [2:0]              prot_i,
  input  wire [1:0]              memtype_i,
  input  wire                    dbg_i,
  input  wire [ACHK_W-1:0]       achk_i,
  input  wire                    rvalid_i,
  input  wire [OBI_DATA_W-1:0]   rdata_i,
  input  wire                    err_i,
  input  wire [RCHK_W-1:0]       rchk_i,
  input  wire                    resp_we_i,
  input  wire                    resp_had_integrity_i,
  input  wire                    integrity_en_i,
  output logic                   achk_fault_o,
  output logic [GRP_W-1:0]       achk_group_o,
  output logic                   rchk_fault_o
);

  achk_u             achk_exp;
  achk_u             achk_got;
  achk_u             achk_diff;
  logic [GRP_W-1:0]  diff_group;
  logic [RCHK_W-1:0] rchk_exp;
  logic              rchk_load_mis;
  logic              rchk_store_mis;

  // Parity of each byte, high byte in the top bit
  function automatic logic [3:0] byte_par(input logic [31:0] word);
    logic [3:0] par;
    for (int i = 0; i < 4; i++) begin
      par[i] = ^word[8*i +: 8];
    end
    return par;
  endfunction

  // Expected request checksum, atop and mid are fixed zero
  always_comb begin
    achk_exp                  = '0;
    achk_exp.fld.wdata_par    = byte_par(wdata_i);
    achk_exp.fld.dbg_ipar     = ~dbg_i;
    achk_exp.fld.atop_par     = 1'b0;
    achk_exp.fld.mid_par      = 1'b0;
    achk_exp.fld.bewe_ipar    = ~^{be_i, we_i};
    achk_exp.fld.protmem_ipar = ~^{prot_i, memtype_i};
    achk_exp.fld.addr_par     = byte_par(addr_i);
  end

  assign achk_got       = achk_i;
  assign achk_diff.flat = achk_exp.flat ^ achk_got.flat;
  assign achk_fault_o   = req_i & gnt_i & integrity_en_i & (|achk_diff.flat);

  // Name the first mismatching group, wdata before control before address
  always_comb begin
    if (|achk_diff.fld.wdata_par) begin
      diff_group = GRP_ACHK_WDATA;
    end else if (|{achk_diff.fld.dbg_ipar, achk_diff.fld.atop_par, achk_diff.fld.mid_par,
                   achk_diff.fld.bewe_ipar, achk_diff.fld.protmem_ipar}) begin
      diff_group = GRP_ACHK_CTRL;
    end else if (|achk_diff.fld.addr_par) begin
      diff_group = GRP_ACHK_ADDR;
    end else begin
      diff_group = GRP_NONE;
    end
  end

  assign achk_group_o = achk_fault_o ? diff_group : GRP_NONE;

  // Expected response checksum, exokay is fixed zero
  assign rchk_exp = {^{err_i, 1'b0}, byte_par(rdata_i)};

  assign rchk_load_mis  = (rchk_exp != rchk_i);
  assign rchk_store_mis = (rchk_exp[RCHK_STORE_BIT] != rchk_i[RCHK_STORE_BIT]);

  // Stores only carry err and exokay in rchk
  assign rchk_fault_o = rvalid_i & resp_had_integrity_i &
                        (resp_we_i ? rchk_store_mis : rchk_load_mis);

  // Flat compare and group decode must agree on every achk fault
  a_achk_fault_on_accept: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    achk_fault_o |-> (req_i && gnt_i && achk_group_o != GRP_NONE)
  ) else $error("achk fault without an accept or without a group");

endmodule

`default_nettype wire

// ==== source/obi_alert_result.sv ====
// Integrity alert, fault counters and Wishbone register slave
// Sticky major alert, saturating counters, CTRL and STATUS registers
`default_nettype none

module obi_alert_result
  import obi_integrity_pkg::*;
(
  input  wire                  clk_i,
  input  wire                  rst_n_i,
  input  wire                  rvalid_i,
  input  wire                  rvalidpar_i,
  input  wire                  par_fault_i,
  input  wire                  gnt_fault_resp_i,
  input  wire                  achk_fault_i,
  input  wire [GRP_W-1:0]      achk_group_i,
  input  wire                  rchk_fault_i,
  input  wire                  wb_cyc_i,
  input  wire                  wb_stb_i,
  input  wire                  wb_we_i,
  input  wire [WB_ADDR_W-1:0]  wb_adr_i,
  input  wire [WB_DATA_W-1:0]  wb_dat_i,
  output logic [WB_DATA_W-1:0] wb_dat_o,
  output logic                 wb_ack_o,
  output logic                 integrity_en_o,
  output logic                 alert_major_o,
  output logic                 resp_integrity_err_o
);

  logic                 ack_d;
  logic                 ack_q;
  logic                 wr_en;
  logic                 ctrl_wr;
  logic                 clr;
  logic                 any_fault;
  logic [GRP_W-1:0]     fault_grp;
  logic                 en_q;
  logic                 alert_q;
  logic [GRP_W-1:0]     grp_q;
  logic [CNT_W-1:0]     par_cnt_q;
  logic [CNT_W-1:0]     achk_cnt_q;
  logic [CNT_W-1:0]     rchk_cnt_q;
  logic [WB_DATA_W-1:0] rd_data;
  logic [WB_DATA_W-1:0] dat_q;

  function automatic logic [CNT_W-1:0] sat_inc(input logic [CNT_W-1:0] cnt);
    return (cnt == '1) ? cnt : cnt + 1'b1;
  endfunction

  // Per-response integrity flag
  assign resp_integrity_err_o = rvalid_i &
                                ((rvalidpar_i == rvalid_i) | gnt_fault_resp_i | rchk_fault_i);

  // Ack lasts one cycle and is followed by a low cycle
  assign ack_d = wb_cyc_i & wb_stb_i & ~ack_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= ack_d;
    end
  end

  assign wr_en   = ack_q & wb_cyc_i & wb_stb_i & wb_we_i;
  assign ctrl_wr = wr_en & (wb_adr_i == REG_CTRL);
  assign clr     = ctrl_wr & wb_dat_i[CTRL_CLR_BIT];

  // Parity faults win the group code, then achk, then rchk
  assign any_fault = par_fault_i | achk_fault_i | rchk_fault_i;
  always_comb begin
    if (par_fault_i) begin
      fault_grp = GRP_PARITY;
    end else if (achk_fault_i) begin
      fault_grp = achk_group_i;
    end else begin
      fault_grp = GRP_RCHK;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      en_q <= 1'b1;
    end else if (ctrl_wr) begin
      en_q <= wb_dat_i[CTRL_EN_BIT];
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || clr) begin
      alert_q    <= 1'b0;
      grp_q      <= GRP_NONE;
      par_cnt_q  <= '0;
      achk_cnt_q <= '0;
      rchk_cnt_q <= '0;
    end else begin
      if (any_fault) begin
        alert_q <= 1'b1;
        grp_q   <= fault_grp;
      end
      if (par_fault_i) begin
        par_cnt_q <= sat_inc(par_cnt_q);
      end
      if (achk_fault_i) begin
        achk_cnt_q <= sat_inc(achk_cnt_q);
      end
      if (rchk_fault_i) begin
        rchk_cnt_q <= sat_inc(rchk_cnt_q);
      end
    end
  end

  always_comb begin
    rd_data = '0;
    case (wb_adr_i)
      REG_CTRL:     rd_data[CTRL_EN_BIT] = en_q;
      REG_STATUS:   rd_data[GRP_W:0] = {grp_q, alert_q};
      REG_PAR_CNT:  rd_data[CNT_W-1:0] = par_cnt_q;
      REG_ACHK_CNT: rd_data[CNT_W-1:0] = achk_cnt_q;
      REG_RCHK_CNT: rd_data[CNT_W-1:0] = rchk_cnt_q;
      default:      rd_data = '0;
    endcase
  end

  // Read data captured as ack rises
  always_ff @(posedge clk_i) begin
    if (ack_d) begin
      dat_q <= rd_data;
    end
  end

  assign wb_dat_o       = dat_q;
  assign wb_ack_o       = ack_q;
  assign integrity_en_o = en_q;
  assign alert_major_o  = alert_q;

  a_ack_follows_strobe: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    wb_ack_o |-> $past(wb_cyc_i && wb_stb_i)
  ) else $error("Wishbone ack without a preceding cycle and strobe");

endmodule

`default_nettype wire

// ==== source/obi_integrity_top.sv ====
// OBI data port integrity monitor top level
// Connects handshake decode, checksum execute and alert result stages
`default_nettype none

module obi_integrity_top
  import obi_integrity_pkg::*;
(
  input  wire                  clk_i,
  input  wire                  rst_n_i,
  // OBI data port, observed only
  input  wire                  req_i,
  input  wire                  reqpar_i,
  input  wire                  gnt_i,
  input  wire                  gntpar_i,
  input  wire [OBI_ADDR_W-1:0] addr_i,
  input  wire [OBI_DATA_W-1:0] wdata_i,
  input  wire [OBI_BE_W-1:0]   be_i,
  input  wire                  we_i,
  input  wire [2:0]            prot_i,
  input  wire [1:0]            memtype_i,
  input  wire                  dbg_i,
  input  wire [ACHK_W-1:0]     achk_i,
  input  wire                  rvalid_i,
  input  wire                  rvalidpar_i,
  input  wire [OBI_DATA_W-1:0] rdata_i,
  input  wire                  err_i,
  input  wire [RCHK_W-1:0]     rchk_i,
  // Wishbone classic slave
  input  wire                  wb_cyc_i,
  input  wire                  wb_stb_i,
  input  wire                  wb_we_i,
  input  wire [WB_ADDR_W-1:0]  wb_adr_i,
  input  wire [WB_DATA_W-1:0]  wb_dat_i,
  output logic [WB_DATA_W-1:0] wb_dat_o,
  output logic                 wb_ack_o,
  output logic                 alert_major_o,
  output logic                 resp_integrity_err_o
);

  logic             integrity_en;
  logic             par_fault;
  logic             resp_we;
  logic             resp_had_integrity;
  logic             gnt_fault_resp;
  logic             achk_fault;
  logic [GRP_W-1:0] achk_group;
  logic             rchk_fault;

  obi_handshake_decode u_decode (
    .clk_i, .rst_n_i, .req_i, .reqpar_i, .gnt_i, .gntpar_i, .rvalid_i, .rvalidpar_i, .we_i,
    .integrity_en_i       (integrity_en),
    .par_fault_o          (par_fault),
    .resp_we_o            (resp_we),
    .resp_had_integrity_o (resp_had_integrity),
    .gnt_fault_resp_o     (gnt_fault_resp)
  );

  obi_checksum_execute u_execute (
    .clk_i, .rst_n_i, .req_i, .gnt_i, .addr_i, .wdata_i, .be_i, .we_i, .prot_i, .memtype_i,
    .dbg_i, .achk_i, .rvalid_i, .rdata_i, .err_i, .rchk_i,
    .resp_we_i            (resp_we),
    .resp_had_integrity_i (resp_had_integrity),
    .integrity_en_i       (integrity_en),
    .achk_fault_o         (achk_fault),
    .achk_group_o         (achk_group),
    .rchk_fault_o         (rchk_fault)
  );

  obi_alert_result u_result (
    .clk_i, .rst_n_i, .rvalid_i, .rvalidpar_i,
    .par_fault_i          (par_fault),
    .gnt_fault_resp_i     (gnt_fault_resp),
    .achk_fault_i         (achk_fault),
    .achk_group_i         (achk_group),
    .rchk_fault_i         (rchk_fault),
    .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i, .wb_dat_o, .wb_ack_o,
    .integrity_en_o       (integrity_en),
    .alert_major_o, .resp_integrity_err_o
  );

endmodule

`default_nettype wire

// ==== tb/tb_clock_gen.sv ====
// Testbench clock and reset source
// Period of 4 time units, reset held low for the first 3 rising edges
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (3) @(posedge clk_o);
    #1 rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// ==== tb/tb_integrity_checker.sv ====
// Integrity monitor output checker
// Compares response flag, alert and register reads on the falling edge
`default_nettype none

module tb_integrity_checker
  import obi_integrity_pkg::*;
(
  input  wire                 clk_i,
  input  wire                 rst_n_i,
  input  wire                 resp_integrity_err_i,
  input  wire                 alert_major_i,
  input  wire                 wb_ack_i,
  input  wire [WB_DATA_W-1:0] wb_dat_i,
  input  wire [15:0]          row_i,
  input  wire                 chk_resp_i,
  input  wire                 exp_resp_i,
  input  wire                 chk_alert_i,
  input  wire                 exp_alert_i,
  input  wire                 chk_rd_i,
  input  wire [WB_DATA_W-1:0] exp_rd_i,
  input  wire                 ack_missing_i,
  input  wire                 row_end_i,
  output int                  rows_passed_o,
  output int                  rows_failed_o,
  output int                  checks_o
);

  logic row_bad;

  // Only the first problem of a row is printed, it becomes the row's line
  task automatic report_mismatch(input string sig, input logic [31:0] exp_val,
                                 input logic [31:0] got_val);
    if (!row_bad) begin
      $display("Fail at time %0t row %0d: %s expected %0h got %0h",
               $time, row_i, sig, exp_val, got_val);
    end
    row_bad = 1'b1;
  endtask

  always @(negedge clk_i) begin
    if (!rst_n_i) begin
      row_bad       = 1'b0;
      rows_passed_o = 0;
      rows_failed_o = 0;
      checks_o      = 0;
    end else begin
      if (chk_resp_i) begin
        checks_o++;
        if (resp_integrity_err_i !== exp_resp_i) begin
          report_mismatch("resp_integrity_err_o", 32'(exp_resp_i), 32'(resp_integrity_err_i));
        end
      end
      if (chk_alert_i) begin
        checks_o++;
        if (alert_major_i !== exp_alert_i) begin
          report_mismatch("alert_major_o", 32'(exp_alert_i), 32'(alert_major_i));
        end
      end
      // Read data is valid with ack
      if (chk_rd_i && wb_ack_i) begin
        checks_o++;
        if (wb_dat_i !== exp_rd_i) begin
          report_mismatch("wb_dat_o", exp_rd_i, wb_dat_i);
        end
      end
      if (ack_missing_i) begin
        if (!row_bad) begin
          $display("Row %0d: the register access never got a Wishbone ack", row_i);
        end
        row_bad = 1'b1;
      end
      if (row_end_i) begin
        if (row_bad) begin
          rows_failed_o++;
        end else begin
          rows_passed_o++;
          $display("Row %0d passed", row_i);
        end
        row_bad = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb/tb_obi_integrity.sv ====
// Testbench for the OBI data port integrity monitor
// Applies a table of OBI transfers and register accesses with injected faults
`default_nettype none

module tb_obi_integrity
  import obi_integrity_pkg::*;
();

  // Row operations and injected corruptions
  localparam int OP_LD      = 0;
  localparam int OP_ST      = 1;
  localparam int OP_WR      = 2;
  localparam int OP_RD      = 3;
  localparam int OP_LD_REEN = 4;
  localparam int F_NONE     = 0;
  localparam int F_REQPAR   = 1;
  localparam int F_GNTPAR   = 2;
  localparam int F_RVPAR    = 3;
  localparam int F_ACHK     = 4;
  localparam int F_RCHK     = 5;
  localparam int MAX_ROWS   = 64;
  localparam int ACK_WAIT   = 4;

  logic clk;
  logic rst_n;
  logic req, reqpar, gnt, gntpar, we, dbg, rvalid, rvalidpar, err;
  logic [OBI_ADDR_W-1:0] addr;
  logic [OBI_DATA_W-1:0] wdata;
  logic [OBI_DATA_W-1:0] rdata;
  logic [OBI_BE_W-1:0]   be;
  logic [2:0]            prot;
  logic [1:0]            memtype;
  logic [ACHK_W-1:0]     achk;
  logic [RCHK_W-1:0]     rchk;
  logic                  wb_cyc, wb_stb, wb_we, wb_ack;
  logic [WB_ADDR_W-1:0]  wb_adr;
  logic [WB_DATA_W-1:0]  wb_dat_w;
  logic [WB_DATA_W-1:0]  wb_dat_r;
  logic                  alert_major;
  logic                  resp_err;

  // Checker control
  logic [15:0]          row_num;
  logic                 chk_resp, exp_resp, chk_alert, exp_alert, chk_rd;
  logic [WB_DATA_W-1:0] exp_rd;
  logic                 ack_missing, row_end;
  int                   rows_passed, rows_failed, checks;

  // Stimulus table, val is write data or expected read data
  int                   row_op    [MAX_ROWS];
  int                   row_fault [MAX_ROWS];
  int                   row_bit   [MAX_ROWS];
  logic [WB_ADDR_W-1:0] row_adr   [MAX_ROWS];
  logic [WB_DATA_W-1:0] row_val   [MAX_ROWS];
  logic                 row_er    [MAX_ROWS];
  logic                 row_al    [MAX_ROWS];
  int                   n_rows;
  logic [31:0]          lfsr_q;
  int                   cycle_cnt;
  int                   cycle_limit;

  tb_clock_gen u_clk (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  obi_integrity_top UUT (
    .clk_i (clk), .rst_n_i (rst_n),
    .req_i (req), .reqpar_i (reqpar), .gnt_i (gnt), .gntpar_i (gntpar),
    .addr_i (addr), .wdata_i (wdata), .be_i (be), .we_i (we), .prot_i (prot),
    .memtype_i (memtype), .dbg_i (dbg), .achk_i (achk),
    .rvalid_i (rvalid), .rvalidpar_i (rvalidpar), .rdata_i (rdata), .err_i (err),
    .rchk_i (rchk),
    .wb_cyc_i (wb_cyc), .wb_stb_i (wb_stb), .wb_we_i (wb_we), .wb_adr_i (wb_adr),
    .wb_dat_i (wb_dat_w), .wb_dat_o (wb_dat_r), .wb_ack_o (wb_ack),
    .alert_major_o (alert_major), .resp_integrity_err_o (resp_err)
  );

  tb_integrity_checker u_checker (
    .clk_i (clk), .rst_n_i (rst_n),
    .resp_integrity_err_i (resp_err), .alert_major_i (alert_major),
    .wb_ack_i (wb_ack), .wb_dat_i (wb_dat_r), .row_i (row_num),
    .chk_resp_i (chk_resp), .exp_resp_i (exp_resp),
    .chk_alert_i (chk_alert), .exp_alert_i (exp_alert),
    .chk_rd_i (chk_rd), .exp_rd_i (exp_rd),
    .ack_missing_i (ack_missing), .row_end_i (row_end),
    .rows_passed_o (rows_passed), .rows_failed_o (rows_failed), .checks_o (checks)
  );

  // Galois LFSR, taps 32 30 26 25
  function automatic logic [31:0] galois_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = galois_step(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic logic [ACHK_W-1:0] calc_achk(input logic [31:0] a, input logic [31:0] wd,
      input logic [3:0] b, input logic w, input logic [2:0] p, input logic [1:0] mt,
      input logic d);
    logic [3:0] wd_par;
    logic [3:0] a_par;
    wd_par = {^wd[31:24], ^wd[23:16], ^wd[15:8], ^wd[7:0]};
    a_par  = {^a[31:24], ^a[23:16], ^a[15:8], ^a[7:0]};
    // atop and mid are absent, so their parity is zero
    return {wd_par, ~d, 1'b0, 1'b0, ~^{b, w}, ~^{p, mt}, a_par};
  endfunction

  // exokay is absent, bit 4 reduces to err
  function automatic logic [RCHK_W-1:0] calc_rchk(input logic e, input logic [31:0] rd);
    return {e, ^rd[31:24], ^rd[23:16], ^rd[15:8], ^rd[7:0]};
  endfunction

  task automatic add_row(input int op, input int fault, input int bitpos,
                         input logic [WB_ADDR_W-1:0] adr, input logic [31:0] val,
                         input logic er, input logic al);
    row_op[n_rows]    = op;
    row_fault[n_rows] = fault;
    row_bit[n_rows]   = bitpos;
    row_adr[n_rows]   = adr;
    row_val[n_rows]   = val;
    row_er[n_rows]    = er;
    row_al[n_rows]    = al;
    n_rows++;
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // Holds cyc and stb until ack has been seen, or gives up
  task automatic wb_access(input logic [WB_ADDR_W-1:0] adr, input logic wr,
                           input logic [WB_DATA_W-1:0] val, output logic got);
    int waited;
    got      = 1'b0;
    waited   = 0;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = wr;
    wb_adr   = adr;
    wb_dat_w = val;
    while (!got && waited < ACK_WAIT) begin
      @(negedge clk);
      if (wb_ack) begin
        got = 1'b1;
      end
      waited++;
      next_cycle();
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic finish_row(input logic got_ack);
    ack_missing = ~got_ack;
    row_end     = 1'b1;
    next_cycle();
    row_end     = 1'b0;
    ack_missing = 1'b0;
    chk_alert   = 1'b0;
    chk_rd      = 1'b0;
  endtask

  task automatic reg_row(input int r);
    logic got;
    if (row_op[r] == OP_RD) begin
      chk_rd = 1'b1;
      exp_rd = row_val[r];
      wb_access(row_adr[r], 1'b0, '0, got);
    end else begin
      wb_access(row_adr[r], 1'b1, row_val[r], got);
    end
    finish_row(got);
  endtask

  // Accept cycle, response cycle, then the alert check
  task automatic obi_transfer(input int r);
    logic              got;
    logic [ACHK_W-1:0] achk_flip;
    logic [RCHK_W-1:0] rchk_flip;
    got       = 1'b1;
    achk_flip = (row_fault[r] == F_ACHK) ? (ACHK_W'(1) << row_bit[r]) : '0;
    rchk_flip = (row_fault[r] == F_RCHK) ? (RCHK_W'(1) << row_bit[r]) : '0;
    we        = (row_op[r] == OP_ST);
    addr      = take_bits(32);
    wdata     = take_bits(32);
    be        = OBI_BE_W'(take_bits(OBI_BE_W));
    prot      = 3'(take_bits(3));
    memtype   = 2'(take_bits(2));
    dbg       = (take_bits(1) != 32'd0);
    achk      = calc_achk(addr, wdata, be, we, prot, memtype, dbg) ^ achk_flip;
    req       = 1'b1;
    gnt       = 1'b1;
    reqpar    = (row_fault[r] == F_REQPAR);
    gntpar    = (row_fault[r] == F_GNTPAR);
    next_cycle();
    req    = 1'b0;
    gnt    = 1'b0;
    reqpar = 1'b1;
    gntpar = 1'b1;
    // Enable flips while the request is still open
    if (row_op[r] == OP_LD_REEN) begin
      wb_access(REG_CTRL, 1'b1, 32'd1, got);
    end
    rdata     = take_bits(32);
    err       = 1'b0;
    rchk      = calc_rchk(err, rdata) ^ rchk_flip;
    rvalid    = 1'b1;
    rvalidpar = (row_fault[r] == F_RVPAR);
    chk_resp  = 1'b1;
    exp_resp  = row_er[r];
    next_cycle();
    rvalid    = 1'b0;
    rvalidpar = 1'b1;
    chk_resp  = 1'b0;
    chk_alert = 1'b1;
    exp_alert = row_al[r];
    finish_row(got);
  endtask

  task automatic build_table();
    n_rows = 0;
    // Reset values
    add_row(OP_RD, F_NONE, 0, REG_CTRL, 32'd1, 1'b0, 1'b0);
    add_row(OP_RD, F_NONE, 0, REG_STATUS, 32'd0, 1'b0, 1'b0);
    add_row(OP_RD, F_NONE, 0, REG_PAR_CNT, 32'd0, 1'b0, 1'b0);
    add_row(OP_RD, F_NONE, 0, REG_ACHK_CNT, 32'd0, 1'b0, 1'b0);
    add_row(OP_RD, F_NONE, 0, REG_RCHK_CNT, 32'd0, 1'b0, 1'b0);
    // Clean traffic
    add_row(OP_LD, F_NONE, 0, REG_CTRL, 32'd0, 1'b0, 1'b0);
    add_row(OP_ST, F_NONE, 0, REG_CTRL, 32'd0, 1'b0, 1'b0);
    add_row(OP_RD, F_NONE, 0, REG_STATUS, 32'd0, 1'b0, 1'b0);
    add_row(OP_RD, F_NONE, 0, REG_PAR_CNT, 32'd0, 1'b0, 1'b0);
    add_row(OP_RD, F_NONE, 0, REG_RCHK_CNT, 32'd0, 1'b0, 1'b0);
    // Handshake parity lines
    add_row(OP_LD, F_GNTPAR, 0, REG_CTRL, 32'd0, 1'b1, 1'b1);
    add_row(OP_RD, F_NONE, 0, REG_PAR_CNT, 32'd1, 1'b0, 1'b0);
    add_row(OP_RD, F_NONE, 0, REG_STATUS, 32'd3, 1'b0, 1'b0);
    add_row(OP_LD, F_REQPAR, 0, REG_CTRL, 32'd0, 1'b0, 1'b1);
    add_row(OP_ST, F_RVPAR, 0, REG_CTRL, 32'd0, 1'b1, 1'b1);
    add_row(OP_RD, F_NONE, 0, REG_PAR_CNT, 32'd3, 1'b0, 1'b0);
    add_row(OP_WR, F_NONE, 0, REG_CTRL, 32'd3, 1'b0, 1'b0);
    add_row(OP_RD, F_NONE, 0, REG_STATUS, 32'd0, 1'b0, 1'b0);
    // Response checksum, stores compare bit 4 only
    add_row(OP_LD, F_RCHK, 2, REG_CTRL, 32'd0, 1'b1, 1'b1);
    add_row(OP_RD, F_NONE, 0, REG_RCHK_CNT, 32'd1, 1'b0, 1'b0);
    add_row(OP_RD, F_NONE, 0, REG_STATUS, 32'd11, 1'b0, 1'b0);
    add_row(OP_WR, F_NONE, 0, REG_CTRL, 32'd3, 1'b0, 1'b0);
    add_row(OP_ST, F_RCHK, 0, REG_CTRL, 32'd0, 1'b0, 1'b0);
    add_row(OP_RD, F_NONE, 0, REG_RCHK_CNT, 32'd0, 1'b0, 1'b0);
    add_row(OP_ST, F_RCHK, 4, REG_CTRL, 32'd0, 1'b1, 1'b1);
    add_row(OP_RD, F_NONE, 0, REG_RCHK_CNT, 32'd1, 1'b0, 1'b0);
    add_row(OP_WR, F_NONE, 0, REG_CTRL, 32'd3, 1'b0, 1'b0);
    // Request checksum groups: wdata, control, address
    add_row(OP_ST, F_ACHK, 12, REG_CTRL, 32'd0, 1'b0, 1'b1);
    add_row(OP_RD, F_NONE, 0, REG_STATUS, 32'd5, 1'b0, 1'b0);
    add_row(OP_LD, F_ACHK, 6, REG_CTRL, 32'd0, 1'b0, 1'b1);
    add_row(OP_RD, F_NONE, 0, REG_STATUS, 32'd7, 1'b0, 1'b0);
    add_row(OP_LD, F_ACHK, 1, REG_CTRL, 32'd0, 1'b0, 1'b1);
    add_row(OP_RD, F_NONE, 0, REG_STATUS, 32'd9, 1'b0, 1'b0);
    add_row(OP_RD, F_NONE, 0, REG_ACHK_CNT, 32'd3, 1'b0, 1'b0);
    add_row(OP_RD, F_NONE, 0, REG_RCHK_CNT, 32'd0, 1'b0, 1'b0);
    // Checking off, then back on for new requests only
    add_row(OP_WR, F_NONE, 0, REG_CTRL, 32'd2, 1'b0, 1'b0);
    add_row(OP_RD, F_NONE, 0, REG_CTRL, 32'd0, 1'b0, 1'b0);
    add_row(OP_RD, F_NONE, 0, REG_STATUS, 32'd0, 1'b0, 1'b0);
    add_row(OP_LD, F_ACHK, 10, REG_CTRL, 32'd0, 1'b0, 1'b0);
    add_row(OP_LD, F_RCHK, 3, REG_CTRL, 32'd0, 1'b0, 1'b0);
    add_row(OP_ST, F_RCHK, 4, REG_CTRL, 32'd0, 1'b0, 1'b0);
    add_row(OP_RD, F_NONE, 0, REG_ACHK_CNT, 32'd0, 1'b0, 1'b0);
    add_row(OP_RD, F_NONE, 0, REG_RCHK_CNT, 32'd0, 1'b0, 1'b0);
    add_row(OP_ST, F_GNTPAR, 0, REG_CTRL, 32'd0, 1'b1, 1'b1);
    add_row(OP_LD, F_RVPAR, 0, REG_CTRL, 32'd0, 1'b1, 1'b1);
    add_row(OP_RD, F_NONE, 0, REG_PAR_CNT, 32'd2, 1'b0, 1'b0);
    add_row(OP_LD_REEN, F_RCHK, 2, REG_CTRL, 32'd0, 1'b0, 1'b1);
    add_row(OP_RD, F_NONE, 0, REG_CTRL, 32'd1, 1'b0, 1'b0);
    add_row(OP_RD, F_NONE, 0, REG_RCHK_CNT, 32'd0, 1'b0, 1'b0);
    add_row(OP_LD, F_RCHK, 1, REG_CTRL, 32'd0, 1'b1, 1'b1);
    add_row(OP_RD, F_NONE, 0, REG_RCHK_CNT, 32'd1, 1'b0, 1'b0);
    add_row(OP_ST, F_ACHK, 3, REG_CTRL, 32'd0, 1'b0, 1'b1);
    add_row(OP_RD, F_NONE, 0, REG_ACHK_CNT, 32'd1, 1'b0, 1'b0);
  endtask

  // Run limit follows the table length
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("TESTS FAILED");
      $finish;
    end
  end

  initial begin
    int r;
    cycle_cnt   = 0;
    lfsr_q      = 32'd76382;
    req         = 1'b0;
    reqpar      = 1'b1;
    gnt         = 1'b0;
    gntpar      = 1'b1;
    addr        = '0;
    wdata       = '0;
    be          = '0;
    we          = 1'b0;
    prot        = '0;
    memtype     = '0;
    dbg         = 1'b0;
    achk        = '0;
    rvalid      = 1'b0;
    rvalidpar   = 1'b1;
    rdata       = '0;
    err         = 1'b0;
    rchk        = '0;
    wb_cyc      = 1'b0;
    wb_stb      = 1'b0;
    wb_we       = 1'b0;
    wb_adr      = '0;
    wb_dat_w    = '0;
    row_num     = '0;
    chk_resp    = 1'b0;
    exp_resp    = 1'b0;
    chk_alert   = 1'b0;
    exp_alert   = 1'b0;
    chk_rd      = 1'b0;
    exp_rd      = '0;
    ack_missing = 1'b0;
    row_end     = 1'b0;
    build_table();
    cycle_limit = n_rows * 8 + 20;
    wait (rst_n == 1'b1);
    next_cycle();
    for (r = 0; r < n_rows; r++) begin
      row_num = 16'(r);
      if (row_op[r] == OP_WR || row_op[r] == OP_RD) begin
        reg_row(r);
      end else begin
        obi_transfer(r);
      end
    end
    next_cycle();
    $display("Summary: %0d rows, %0d passed, %0d failed, %0d checks",
             n_rows, rows_passed, rows_failed, checks);
    if (rows_failed == 0 && rows_passed == n_rows) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
source/obi_integrity_pkg.sv
source/obi_handshake_decode.sv
source/obi_checksum_execute.sv
source/obi_alert_result.sv
source/obi_integrity_top.sv
tb/tb_clock_gen.sv
tb/tb_integrity_checker.sv
tb/tb_obi_integrity.sv
